//--- sim/core_stimulus.txt
# M addr data is a program or data word, W addr data an expected store in order.
# H ends a test that halts on ebreak, E one that halts on a bus error.
M 00000000 123450b7  # lui  x1, 0x12345
M 00000004 67808093  # addi x1, x1, 0x678
M 00000008 10000113  # addi x2, x0, 0x100
M 0000000c ffb00193  # addi x3, x0, -5
M 00000010 00308233  # add  x4, x1, x3
M 00000014 403082b3  # sub  x5, x1, x3
M 00000018 00524333  # xor  x6, x4, x5
M 0000001c 0032f3b3  # and  x7, x5, x3
M 00000020 00236433  # or   x8, x6, x2
M 00000024 00412023  # sw   x4, 0(x2)
M 00000028 00512223  # sw   x5, 4(x2)
M 0000002c 00612423  # sw   x6, 8(x2)
M 00000030 00712623  # sw   x7, 12(x2)
M 00000034 00812823  # sw   x8, 16(x2)
M 00000038 08012483  # lw   x9, 0x80(x2)
M 0000003c 08412503  # lw   x10, 0x84(x2)
M 00000040 00a485b3  # add  x11, x9, x10
M 00000044 00b12a23  # sw   x11, 20(x2)
M 00000048 00a48463  # beq  x9, x10, +8 not taken
M 0000004c 00100613  # addi x12, x0, 1
M 00000050 00a49463  # bne  x9, x10, +8 taken
M 00000054 00312c23  # sw   x3, 24(x2) skipped
M 00000058 00b58463  # beq  x11, x11, +8 taken
M 0000005c 00312c23  # sw   x3, 24(x2) skipped
M 00000060 00c61463  # bne  x12, x12, +8 not taken
M 00000064 00260613  # addi x12, x12, 2
M 00000068 00c12c23  # sw   x12, 24(x2)
M 0000006c 008006ef  # jal  x13, +8
M 00000070 00312e23  # sw   x3, 28(x2) skipped
M 00000074 00d12e23  # sw   x13, 28(x2)
M 00000078 00100073  # ebreak
M 0000007c 02312023  # sw   x3, 32(x2) after halt
M 00000180 00001111
M 00000184 22220000
W 00000100 12345673
W 00000104 1234567d
W 00000108 0000000e
W 0000010c 12345679
W 00000110 0000010e
W 00000114 22221111
W 00000118 00000003
W 0000011c 00000070
H
# Load from the error region ends the run.
M 00000000 100000b7  # lui  x1, 0x10000
M 00000004 10000113  # addi x2, x0, 0x100
M 00000008 00112023  # sw   x1, 0(x2)
M 0000000c 0000a183  # lw   x3, 0(x1) bus error
M 00000010 00212223  # sw   x2, 4(x2) never
M 00000014 00100073  # ebreak
W 00000100 10000000
E

//--- project.f
verilog/core_pkg.sv
verilog/bus_if.sv
verilog/fetch_unit.sv
verilog/decoder.sv
verilog/execute_unit.sv
verilog/load_store_unit.sv
verilog/register_file.sv
verilog/bus_arbiter.sv
verilog/core_top.sv
sim/core_checker.sv
sim/tb_core.sv

//--- sim/tb_core.sv
`timescale 1ns/100ps
module tb_core;

	localparam logic [31:0] SEED        = 32'h72ba2f44;
	localparam logic [31:0] ERROR_BASE  = 32'h1000_0000;
	localparam logic [31:0] EBREAK      = 32'h0010_0073;
	localparam int          MEM_WORDS   = 256;
	localparam int          DELAY_SLOTS = 256;
	localparam int          WORD_BUDGET = 40;  // Cycles per program word.
	localparam int          TEST_SLACK  = 40;  // Reset and settle per test.
	localparam int          SETTLE      = 10;

	logic        clock;
	logic        rst_n;
	logic [31:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	logic [31:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic        retire;
	logic [31:0] retire_pc;
	logic        halted;
	logic        bus_error;

	logic [31:0] mem [MEM_WORDS];
	logic [31:0] image_addr [$];
	logic [31:0] image_data [$];
	int          image_test [$];
	logic [31:0] store_addr [$];
	logic [31:0] store_data [$];
	int          store_test [$];
	bit          expect_fault [$];
	int unsigned delay_table [DELAY_SLOTS];
	int          delay_pick = 0;
	int          total_words = 0;
	bit          loaded = 1'b0;

	core_top UUT (.*);

	core_checker store_check (
		.clock, .rst_n, .awaddr, .awvalid, .awready, .wdata, .wstrb,
		.arvalid, .retire, .retire_pc, .halted, .bus_error
	);

	function automatic int word_index(input logic [31:0] addr);
		return (addr >> 2) % MEM_WORDS;
	endfunction

	function automatic int next_delay();
		int d;
		d = delay_table[delay_pick];
		delay_pick = (delay_pick + 1) % DELAY_SLOTS;
		return d;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic read_stimulus(output string problem);
		int                fd;
		int                code;
		int                test;
		logic [7:0]        kind;
		logic [31:0]       a;
		logic [31:0]       d;
		logic [8*160-1:0]  line_buf;
		test    = 0;
		problem = "";
		fd = $fopen("sim/core_stimulus.txt", "r");
		if (fd == 0) begin
			problem = "cannot open the stimulus file";
		end else begin
			while (problem == "" && $fscanf(fd, " %c", kind) == 1) begin
				if (kind == "#") begin
					code = $fgets(line_buf, fd);  // Rest of a comment.
				end else if (kind == "M" || kind == "W") begin
					code = $fscanf(fd, "%h %h", a, d);
					if (code != 2) begin
						problem = "malformed record in the stimulus file";
					end else if (kind == "M") begin
						image_addr.push_back(a);
						image_data.push_back(d);
						image_test.push_back(test);
						total_words++;
					end else begin
						store_addr.push_back(a);
						store_data.push_back(d);
						store_test.push_back(test);
					end
				end else if (kind == "E" || kind == "H") begin
					expect_fault.push_back(kind == "E");
					test++;
				end else begin
					problem = "unknown record kind in the stimulus file";
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_test(input int id);
		logic [31:0] stop_pc;
		bit          found;
		stop_pc = '1;
		found   = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = 32'h6b00_0000 ^ (i * 4);
		foreach (image_addr[k])
			if (image_test[k] == id) begin
				mem[word_index(image_addr[k])] = image_data[k];
				if (!found && image_data[k] == EBREAK) begin
					stop_pc = image_addr[k];
					found   = 1'b1;
				end
			end
		foreach (store_addr[k])
			if (store_test[k] == id)
				store_check.expect_store(store_addr[k], store_data[k]);
		@(posedge clock);
		rst_n <= 1'b0;
		repeat (3) @(posedge clock);
		store_check.begin_test(id, expect_fault[id], stop_pc);
		rst_n <= 1'b1;
		wait (halted === 1'b1);
		repeat (SETTLE) @(posedge clock);  // Window for stray requests.
		@(negedge clock);
		store_check.end_test();
	endtask

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// Read channel of the memory model.
	initial begin : read_channel
		int          delay;
		logic [31:0] addr;
		forever begin
			@(posedge clock);
			if (rst_n && arvalid) begin
				delay = next_delay();
				repeat (delay) @(posedge clock);
				arready <= 1'b1;
				@(posedge clock);
				arready <= 1'b0;
				addr = araddr;
				delay = next_delay();
				repeat (delay) @(posedge clock);
				rvalid <= 1'b1;
				rresp  <= (addr >= ERROR_BASE) ? 2'd2 : 2'd0;
				rdata  <= (addr >= ERROR_BASE) ? 32'h0 : mem[word_index(addr)];
				@(posedge clock);
				while (!rready)
					@(posedge clock);
				rvalid <= 1'b0;
			end
		end
	end

	initial begin : write_channel
		int          delay;
		logic [31:0] addr;
		bit          fault;
		forever begin
			@(posedge clock);
			if (rst_n && awvalid && wvalid) begin
				delay = next_delay();
				repeat (delay) @(posedge clock);
				awready <= 1'b1;
				wready  <= 1'b1;
				@(posedge clock);
				awready <= 1'b0;
				wready  <= 1'b0;
				addr  = awaddr;
				fault = (addr >= ERROR_BASE);
				if (!fault)
					mem[word_index(addr)] = wdata;
				delay = next_delay();
				repeat (delay) @(posedge clock);
				bvalid <= 1'b1;
				bresp  <= fault ? 2'd2 : 2'd0;
				@(posedge clock);
				while (!bready)
					@(posedge clock);
				bvalid <= 1'b0;
			end
		end
	end

	initial begin : watchdog
		wait (loaded);
		repeat (WORD_BUDGET * total_words + TEST_SLACK * expect_fault.size())
			@(posedge clock);
		abort_run("watchdog expired before the core halted");
	end

	initial begin : main
		string problem;
		rst_n   = 1'b0;
		arready = 1'b0;
		rdata   = 32'h0;
		rresp   = 2'd0;
		rvalid  = 1'b0;
		awready = 1'b0;
		wready  = 1'b0;
		bresp   = 2'd0;
		bvalid  = 1'b0;
		delay_table[0] = $urandom(SEED) % 4;
		for (int i = 1; i < DELAY_SLOTS; i++)
			delay_table[i] = $urandom % 4;
		read_stimulus(problem);
		if (problem == "" && expect_fault.size() == 0)
			problem = "the stimulus file holds no test";
		if (problem != "") begin
			abort_run(problem);
		end else begin
			loaded = 1'b1;
			for (int t = 0; t < expect_fault.size(); t++)
				run_test(t);
			store_check.report();
			if (store_check.error_count == 0)
				$display("TEST OK");
			else
				$display("TEST FAILED");
			$finish;
		end
	end

endmodule

//--- sim/core_checker.sv
`timescale 1ns/100ps
module core_checker import core_pkg::*; (
	input logic        clock,
	input logic        rst_n,
	input logic [31:0] awaddr,
	input logic        awvalid,
	input logic        awready,
	input logic [31:0] wdata,
	input logic [3:0]  wstrb,
	input logic        arvalid,
	input logic        retire,
	input logic [31:0] retire_pc,
	input logic        halted,
	input logic        bus_error
);

	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] halt_pc;
	logic [31:0] last_pc;
	int          error_count = 0;
	int          errors_before;
	int          tests_done = 0;
	int          test_id;
	int          stores_seen;
	int          stores_total = 0;
	int          retires_seen;
	bit          want_error;
	bit          late_flagged;
	bit          active = 1'b0;

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic begin_test(input int id, input bit fault, input logic [31:0] stop_pc);
		test_id       = id;
		want_error    = fault;
		halt_pc       = stop_pc;
		last_pc       = 'x;
		retires_seen  = 0;
		stores_seen   = 0;
		late_flagged  = 1'b0;
		errors_before = error_count;
		active        = 1'b1;
	endtask

	task automatic end_test();
		active = 1'b0;
		if (exp_addr.size() != 0) begin
			$display("test %0d: %0d expected stores never appeared", test_id, exp_addr.size());
			error_count++;
			exp_addr.delete();
			exp_data.delete();
		end
		if (bus_error !== want_error) begin
			$display("error bus_error expected %h got %h", want_error, bus_error);
			error_count++;
		end
		// An ebreak run retires the ebreak last.
		if (!want_error && last_pc !== halt_pc) begin
			$display("error retire_pc expected %h got %h", halt_pc, last_pc);
			error_count++;
		end
		tests_done++;
		stores_total += stores_seen;
		$display("test %0d finished: %0d stores checked, %0d errors", test_id, stores_seen,
			error_count - errors_before);
	endtask

	task automatic report();
		$display("%0d tests run, %0d stores checked, %0d errors", tests_done, stores_total,
			error_count);
	endtask

	always @(posedge clock) begin : watch
		logic [31:0] addr;
		logic [31:0] data;
		if (active && rst_n) begin
			if (awvalid && awready) begin
				if (exp_addr.size() == 0) begin
					$display("unexpected store of %h to address %h", wdata, awaddr);
					error_count++;
				end else begin
					addr = exp_addr.pop_front();
					data = exp_data.pop_front();
					stores_seen++;
					if (awaddr !== addr) begin
						$display("error awaddr expected %h got %h", addr, awaddr);
						error_count++;
					end
					if (wdata !== data) begin
						$display("error wdata expected %h got %h", data, wdata);
						error_count++;
					end
					if (wstrb !== 4'hf) begin
						$display("error wstrb expected %h got %h", 4'hf, wstrb);
						error_count++;
					end
				end
			end
			if (retire) begin
				if (retires_seen == 0 && retire_pc !== RESET_PC) begin
					$display("error retire_pc expected %h got %h", RESET_PC, retire_pc);
					error_count++;
				end
				last_pc = retire_pc;
				retires_seen++;
			end
			// Halted core must stay silent.
			if (halted && (arvalid || awvalid || retire) && !late_flagged) begin
				$display("bus request or retire seen after the core halted");
				error_count++;
				late_flagged = 1'b1;
			end
		end
	end

endmodule

//--- verilog/core_top.sv
`timescale 1ns/100ps
module core_top import core_pkg::*; (
	input  logic              clock,
	input  logic              rst_n,
	output logic [XLEN-1:0]   araddr,
	output logic              arvalid,
	input  logic              arready,
	input  logic [XLEN-1:0]   rdata,
	input  logic [1:0]        rresp,
	input  logic              rvalid,
	output logic              rready,
	output logic [XLEN-1:0]   awaddr,
	output logic              awvalid,
	input  logic              awready,
	output logic [XLEN-1:0]   wdata,
	output logic [XLEN/8-1:0] wstrb,
	output logic              wvalid,
	input  logic              wready,
	input  logic [1:0]        bresp,
	input  logic              bvalid,
	output logic              bready,
	output logic              retire,
	output logic [XLEN-1:0]   retire_pc,
	output logic              halted,
	output logic              bus_error
);

	bus_if fetch_bus ();
	bus_if data_bus ();

	logic [XLEN-1:0]   instr;
	logic [XLEN-1:0]   pc;
	logic [XLEN-1:0]   next_pc;
	logic [XLEN-1:0]   imm;
	logic [XLEN-1:0]   src1;
	logic [XLEN-1:0]   src2;
	logic [XLEN-1:0]   result;
	logic [XLEN-1:0]   load_data;
	logic [XLEN-1:0]   rf_wdata;
	opcode_e           opcode;
	alu_op_e           alu_op;
	logic [REG_AW-1:0] rs1;
	logic [REG_AW-1:0] rs2;
	logic [REG_AW-1:0] rd;
	logic              use_imm;
	logic              writes_rd;
	logic              is_mem;
	logic              is_load;
	logic              is_halt;
	logic              branch_ne;
	logic              exec_valid;
	logic              reg_write_en;
	logic              rf_wen;
	logic              mem_start;
	logic              mem_done;
	logic              mem_error;

	assign mem_start = exec_valid && is_mem;
	assign rf_wen    = reg_write_en && writes_rd;
	assign rf_wdata  = is_load ? load_data : result;
	assign retire_pc = pc;  // PC still holds the retiring instruction.

	fetch_unit u_fetch (
		.clock, .rst_n, .is_mem, .is_halt, .next_pc, .mem_done, .mem_error,
		.instr, .bus(fetch_bus.requester), .pc, .exec_valid, .reg_write_en,
		.retire, .halted, .bus_error
	);

	decoder u_decoder (
		.instr, .opcode, .rs1, .rs2, .rd, .imm, .alu_op, .use_imm,
		.writes_rd, .is_mem, .is_load, .is_halt, .branch_ne
	);

	execute_unit u_execute (
		.pc, .src1, .src2, .imm, .opcode, .alu_op, .use_imm, .branch_ne,
		.result, .next_pc
	);

	load_store_unit u_lsu (
		.clock, .rst_n, .start(mem_start), .is_load, .addr(result), .store_data(src2),
		.bus(data_bus.requester), .load_data, .done(mem_done), .error(mem_error)
	);

	register_file u_regs (
		.clock, .raddr1(rs1), .raddr2(rs2), .waddr(rd), .wdata(rf_wdata),
		.wen(rf_wen), .rdata1(src1), .rdata2(src2)
	);

	bus_arbiter u_arbiter (
		.clock, .rst_n, .fetch(fetch_bus.completer), .data(data_bus.completer),
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready
	);

endmodule

//--- verilog/bus_arbiter.sv
`timescale 1ns/100ps
module bus_arbiter import core_pkg::*; (
	input  logic              clock,
	input  logic              rst_n,
	bus_if.completer          fetch,
	bus_if.completer          data,
	output logic [XLEN-1:0]   araddr,
	output logic              arvalid,
	input  logic              arready,
	input  logic [XLEN-1:0]   rdata,
	input  logic [1:0]        rresp,
	input  logic              rvalid,
	output logic              rready,
	output logic [XLEN-1:0]   awaddr,
	output logic              awvalid,
	input  logic              awready,
	output logic [XLEN-1:0]   wdata,
	output logic [XLEN/8-1:0] wstrb,
	output logic              wvalid,
	input  logic              wready,
	input  logic [1:0]        bresp,
	input  logic              bvalid,
	output logic              bready
);

	logic busy;
	logic sel_data;
	logic fetch_gnt;
	logic data_gnt;

	assign fetch_gnt = busy && !sel_data;
	assign data_gnt  = busy && sel_data;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			sel_data <= 1'b0;
		end else if (!busy) begin
			if (data.arvalid || data.awvalid) begin  // Load/store has priority.
				busy     <= 1'b1;
				sel_data <= 1'b1;
			end else if (fetch.arvalid) begin
				busy     <= 1'b1;
				sel_data <= 1'b0;
			end
		end else if ((rvalid && rready) || (bvalid && bready)) begin
			busy <= 1'b0;
		end
	end

	assign araddr  = sel_data ? data.araddr : fetch.araddr;
	assign arvalid = (data_gnt && data.arvalid) || (fetch_gnt && fetch.arvalid);
	assign rready  = (data_gnt && data.rready) || (fetch_gnt && fetch.rready);
	assign awaddr  = data.awaddr;
	assign awvalid = data_gnt && data.awvalid;
	assign wdata   = data.wdata;
	assign wstrb   = '1;  // Word accesses only.
	assign wvalid  = data_gnt && data.wvalid;
	assign bready  = data_gnt && data.bready;

	assign fetch.arready = fetch_gnt && arready;
	assign fetch.rdata   = rdata;
	assign fetch.rresp   = rresp;
	assign fetch.rvalid  = fetch_gnt && rvalid;
	assign fetch.awready = 1'b0;
	assign fetch.wready  = 1'b0;
	assign fetch.bresp   = RESP_OKAY;
	assign fetch.bvalid  = 1'b0;

	assign data.arready = data_gnt && arready;
	assign data.rdata   = rdata;
	assign data.rresp   = rresp;
	assign data.rvalid  = data_gnt && rvalid;
	assign data.awready = data_gnt && awready;
	assign data.wready  = data_gnt && wready;
	assign data.bresp   = bresp;
	assign data.bvalid  = data_gnt && bvalid;

endmodule

//--- verilog/register_file.sv
`timescale 1ns/100ps
module register_file import core_pkg::*; (
	input  logic              clock,
	input  logic [REG_AW-1:0] raddr1,
	input  logic [REG_AW-1:0] raddr2,
	input  logic [REG_AW-1:0] waddr,
	input  logic [XLEN-1:0]   wdata,
	input  logic              wen,
	output logic [XLEN-1:0]   rdata1,
	output logic [XLEN-1:0]   rdata2
);

	logic [XLEN-1:0] regs [REG_COUNT];

	always_ff @(posedge clock) begin
		if (wen && waddr != '0)
			regs[waddr] <= wdata;
	end

	// x0 reads as zero.
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- verilog/load_store_unit.sv
`timescale 1ns/100ps
module load_store_unit import core_pkg::*; (
	input  logic            clock,
	input  logic            rst_n,
	input  logic            start,
	input  logic            is_load,
	input  logic [XLEN-1:0] addr,
	input  logic [XLEN-1:0] store_data,
	bus_if.requester        bus,
	output logic [XLEN-1:0] load_data,
	output logic            done,
	output logic            error
);

	logic [XLEN-1:0] addr_q;
	logic [XLEN-1:0] data_q;
	logic            ar_pend;
	logic            aw_pend;
	logic            w_pend;
	logic            r_wait;
	logic            b_wait;
	logic            r_done;
	logic            b_done;

	assign bus.araddr  = addr_q;
	assign bus.arvalid = ar_pend;
	assign bus.rready  = r_wait;
	assign bus.awaddr  = addr_q;
	assign bus.awvalid = aw_pend;
	assign bus.wdata   = data_q;
	assign bus.wvalid  = w_pend;
	assign bus.bready  = b_wait;

	assign r_done    = r_wait && bus.rvalid;
	assign b_done    = b_wait && bus.bvalid;
	assign done      = r_done || b_done;
	assign error     = (r_done && bus.rresp != RESP_OKAY) || (b_done && bus.bresp != RESP_OKAY);
	assign load_data = bus.rdata;  // Written back in the r transfer cycle.

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			ar_pend <= 1'b0;
			aw_pend <= 1'b0;
			w_pend  <= 1'b0;
			r_wait  <= 1'b0;
			b_wait  <= 1'b0;
		end else if (start) begin
			ar_pend <= is_load;
			r_wait  <= is_load;
			aw_pend <= !is_load;
			w_pend  <= !is_load;
			b_wait  <= !is_load;
		end else begin
			ar_pend <= ar_pend && !bus.arready;
			aw_pend <= aw_pend && !bus.awready;
			w_pend  <= w_pend && !bus.wready;
			r_wait  <= r_wait && !r_done;
			b_wait  <= b_wait && !b_done;
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			addr_q <= addr;
			data_q <= store_data;
		end
	end

endmodule

//--- verilog/execute_unit.sv
`timescale 1ns/100ps
module execute_unit import core_pkg::*; (
	input  logic [XLEN-1:0] pc,
	input  logic [XLEN-1:0] src1,
	input  logic [XLEN-1:0] src2,
	input  logic [XLEN-1:0] imm,
	input  opcode_e         opcode,
	input  alu_op_e         alu_op,
	input  logic            use_imm,
	input  logic            branch_ne,
	output logic [XLEN-1:0] result,
	output logic [XLEN-1:0] next_pc
);

	logic [XLEN-1:0] operand_b;
	logic [XLEN-1:0] alu_out;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] pc_target;
	logic            taken;

	assign operand_b = use_imm ? imm : src2;
	assign pc_plus4  = pc + 32'd4;
	assign pc_target = pc + imm;

	// Equality flips for bne.
	assign taken = (opcode == OP_BRANCH) && ((src1 == src2) != branch_ne);

	always_comb begin
		case (alu_op)
			ALU_ADD: alu_out = src1 + operand_b;
			ALU_SUB: alu_out = src1 - operand_b;
			ALU_AND: alu_out = src1 & operand_b;
			ALU_OR:  alu_out = src1 | operand_b;
			ALU_XOR: alu_out = src1 ^ operand_b;
			default: alu_out = operand_b;
		endcase
	end

	assign result  = (opcode == OP_JAL) ? pc_plus4 : alu_out;  // Link address.
	assign next_pc = (opcode == OP_JAL || taken) ? pc_target : pc_plus4;

endmodule

//--- verilog/decoder.sv
`timescale 1ns/100ps
module decoder import core_pkg::*; (
	input  logic [XLEN-1:0]   instr,
	output opcode_e           opcode,
	output logic [REG_AW-1:0] rs1,
	output logic [REG_AW-1:0] rs2,
	output logic [REG_AW-1:0] rd,
	output logic [XLEN-1:0]   imm,
	output alu_op_e           alu_op,
	output logic              use_imm,
	output logic              writes_rd,
	output logic              is_mem,
	output logic              is_load,
	output logic              is_halt,
	output logic              branch_ne
);

	logic [2:0]      funct3;
	logic            funct7_alt;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;

	assign opcode     = opcode_e'(instr[6:0]);
	assign rd         = instr[7 +: REG_AW];  // RV32E uses the low four bits.
	assign rs1        = instr[15 +: REG_AW];
	assign rs2        = instr[20 +: REG_AW];
	assign funct3     = instr[14:12];
	assign funct7_alt = instr[30];
	assign branch_ne  = (funct3 == F3_BNE);

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		imm       = imm_i;
		use_imm   = 1'b0;
		writes_rd = 1'b0;
		is_mem    = 1'b0;
		is_load   = 1'b0;
		is_halt   = 1'b0;
		case (opcode)
			OP_LUI: begin
				imm       = imm_u;
				use_imm   = 1'b1;
				writes_rd = 1'b1;
			end
			OP_IMM: begin
				use_imm   = 1'b1;
				writes_rd = 1'b1;
			end
			OP_REG: writes_rd = 1'b1;
			OP_LOAD: begin
				use_imm   = 1'b1;
				writes_rd = 1'b1;
				is_mem    = 1'b1;
				is_load   = 1'b1;
			end
			OP_STORE: begin
				imm     = imm_s;
				use_imm = 1'b1;
				is_mem  = 1'b1;
			end
			OP_BRANCH: imm = imm_b;
			OP_JAL: begin
				imm       = imm_j;
				writes_rd = 1'b1;
			end
			OP_SYSTEM: is_halt = 1'b1;  // Only ebreak is expected.
			default: ;
		endcase
	end

	always_comb begin
		alu_op = ALU_ADD;  // Address math for loads and stores.
		if (opcode == OP_LUI) begin
			alu_op = ALU_PASS_B;
		end else if (opcode == OP_REG || opcode == OP_IMM) begin
			case (funct3)
				F3_ADD_SUB: alu_op = (opcode == OP_REG && funct7_alt) ? ALU_SUB : ALU_ADD;
				F3_XOR:     alu_op = ALU_XOR;
				F3_OR:      alu_op = ALU_OR;
				F3_AND:     alu_op = ALU_AND;
				default:    alu_op = ALU_ADD;
			endcase
		end
	end

endmodule

//--- verilog/fetch_unit.sv
`timescale 1ns/100ps
module fetch_unit import core_pkg::*; (
	input  logic            clock,
	input  logic            rst_n,
	input  logic            is_mem,
	input  logic            is_halt,
	input  logic [XLEN-1:0] next_pc,
	input  logic            mem_done,
	input  logic            mem_error,
	output logic [XLEN-1:0] instr,
	bus_if.requester        bus,
	output logic [XLEN-1:0] pc,
	output logic            exec_valid,
	output logic            reg_write_en,
	output logic            retire,
	output logic            halted,
	output logic            bus_error
);

	core_state_e state;
	logic        r_wait;
	logic        fetch_done;
	logic        fetch_ok;
	logic        mem_ok;

	assign bus.araddr  = pc;
	assign bus.arvalid = (state == ST_FETCH) && !r_wait;
	assign bus.rready  = r_wait;
	assign bus.awaddr  = '0;  // Read-only requester.
	assign bus.awvalid = 1'b0;
	assign bus.wdata   = '0;
	assign bus.wvalid  = 1'b0;
	assign bus.bready  = 1'b0;

	assign fetch_done = r_wait && bus.rvalid;
	assign fetch_ok   = fetch_done && (bus.rresp == RESP_OKAY);
	assign mem_ok     = (state == ST_MEM) && mem_done && !mem_error;

	assign exec_valid   = (state == ST_EXEC);
	assign reg_write_en = mem_ok || (exec_valid && !is_mem && !is_halt);
	assign retire       = reg_write_en || (exec_valid && is_halt);
	assign halted       = (state == ST_HALT);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state     <= ST_FETCH;
			r_wait    <= 1'b0;
			pc        <= RESET_PC;
			bus_error <= 1'b0;
		end else begin
			if (bus.arvalid && bus.arready)
				r_wait <= 1'b1;
			else if (fetch_done)
				r_wait <= 1'b0;
			if (retire)
				pc <= next_pc;
			case (state)
				ST_FETCH: begin
					if (fetch_done) begin
						state     <= fetch_ok ? ST_EXEC : ST_HALT;
						bus_error <= !fetch_ok;
					end
				end
				ST_EXEC: begin
					if (is_halt)
						state <= ST_HALT;
					else if (is_mem)
						state <= ST_MEM;
					else
						state <= ST_FETCH;
				end
				ST_MEM: begin
					if (mem_done) begin
						state     <= mem_error ? ST_HALT : ST_FETCH;
						bus_error <= mem_error;
					end
				end
				default: state <= ST_HALT;  // Stays here until reset.
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_ok)
			instr <= bus.rdata;
	end

endmodule

//--- verilog/bus_if.sv
`timescale 1ns/100ps
interface bus_if import core_pkg::*; ();

	logic [XLEN-1:0] araddr;
	logic            arvalid;
	logic            arready;
	logic [XLEN-1:0] rdata;
	logic [1:0]      rresp;
	logic            rvalid;
	logic            rready;
	logic [XLEN-1:0] awaddr;
	logic            awvalid;
	logic            awready;
	logic [XLEN-1:0] wdata;
	logic            wvalid;
	logic            wready;
	logic [1:0]      bresp;
	logic            bvalid;
	logic            bready;

	modport requester (
		output araddr, arvalid, rready, awaddr, awvalid, wdata, wvalid, bready,
		input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
	);

	modport completer (
		input  araddr, arvalid, rready, awaddr, awvalid, wdata, wvalid, bready,
		output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
	);

endinterface

//--- verilog/core_pkg.sv
package core_pkg;

	localparam int XLEN      = 32;
	localparam int REG_COUNT = 16;
	localparam int REG_AW    = $clog2(REG_COUNT);

	localparam logic [XLEN-1:0] RESET_PC  = 32'h0000_0000;
	localparam logic [1:0]      RESP_OKAY = 2'b00;

	// funct3 codes used by the ALU and branch decode.
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_BNE     = 3'b001;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111,
		OP_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		ST_FETCH,
		ST_EXEC,
		ST_MEM,
		ST_HALT
	} core_state_e;

endpackage
